// File: common/lsu_pkg.sv
package lsu_pkg;

    localparam int xlen       = 64;
    localparam int addr_w     = 32;
    localparam int lane_bytes = 8;
    localparam int lane_idx_w = 3;

    localparam logic [1:0] resp_okay = 2'b00;

    typedef enum logic [1:0] {
        size_b = 2'd0,
        size_h = 2'd1,
        size_w = 2'd2,
        size_d = 2'd3
    } mem_size_t;

    // Request from the pipeline.
    typedef struct packed {
        logic              store;
        logic [addr_w-1:0] addr;
        mem_size_t         size;
        logic              is_unsigned;
        logic [xlen-1:0]   wdata;
    } lsu_req_t;

    // One beat on the bus, always double-word aligned.
    typedef struct packed {
        logic [addr_w-1:0]     addr;
        logic [lane_bytes-1:0] strb;
        logic [xlen-1:0]       data;
        logic                  store;
        logic                  last;
    } bus_beat_t;

    typedef struct packed {
        logic [lane_idx_w-1:0] offset;
        mem_size_t             size;
        logic                  is_unsigned;
        logic                  store;
        logic                  two_beat;
    } beat_ctx_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        logic            err;
    } lsu_rsp_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } axi_aw_t;

    typedef struct packed {
        logic [xlen-1:0]       data;
        logic [lane_bytes-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } axi_ar_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        logic [1:0]      resp;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

endpackage

// File: source/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
    parameter type T = logic
) (
    input  logic device_unalign,
    input  logic rst_n,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    T           mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // Ready comes from the count only, so no path from out_ready.
    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge device_unalign) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge device_unalign) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

endmodule

// File: source/access_split.sv
`timescale 1ns/1ps

module access_split (
    input  logic                device_unalign,
    input  logic                rst_n,
    input  logic                req_valid,
    output logic                req_ready,
    input  lsu_pkg::lsu_req_t   req,
    output logic                beat_valid,
    input  logic                beat_ready,
    output lsu_pkg::bus_beat_t  beat,
    output lsu_pkg::beat_ctx_t  ctx
);

    lsu_pkg::lsu_req_t               req_q;
    logic                            busy_q;
    logic                            second_q;
    logic [lsu_pkg::lane_idx_w-1:0]  offset;
    logic [3:0]                      nbytes;
    logic                            two_beat;
    logic [2*lsu_pkg::lane_bytes-1:0] strb_wide;
    logic [2*lsu_pkg::xlen-1:0]      data_wide;
    logic [lsu_pkg::addr_w-1:0]      addr_lo;
    logic [lsu_pkg::addr_w-1:0]      addr_hi;

    assign offset = req_q.addr[lsu_pkg::lane_idx_w-1:0];

    always_comb begin
        case (req_q.size)
            lsu_pkg::size_b: nbytes = 4'd1;
            lsu_pkg::size_h: nbytes = 4'd2;
            lsu_pkg::size_w: nbytes = 4'd4;
            default:         nbytes = 4'd8;
        endcase
    end

    // Crosses a double-word boundary.
    assign two_beat = ({1'b0, offset} + nbytes) > 4'd8;

    assign strb_wide = ((16'h1 << nbytes) - 16'h1) << offset;
    assign data_wide = {{lsu_pkg::xlen{1'b0}}, req_q.wdata} << {offset, 3'b000};

    assign addr_lo = {req_q.addr[lsu_pkg::addr_w-1:lsu_pkg::lane_idx_w], 3'b000};
    assign addr_hi = {req_q.addr[lsu_pkg::addr_w-1:lsu_pkg::lane_idx_w] + 1'b1, 3'b000};

    always_comb begin
        beat.addr  = second_q ? addr_hi : addr_lo;
        beat.strb  = second_q ? strb_wide[15:8] : strb_wide[7:0];
        beat.data  = second_q ? data_wide[127:64] : data_wide[63:0];
        beat.store = req_q.store;
        beat.last  = second_q || !two_beat;
    end

    assign ctx.offset      = offset;
    assign ctx.size        = req_q.size;
    assign ctx.is_unsigned = req_q.is_unsigned;
    assign ctx.store       = req_q.store;
    assign ctx.two_beat    = two_beat;

    assign req_ready  = !busy_q;
    assign beat_valid = busy_q;

    always_ff @(posedge device_unalign) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
    end

    always_ff @(posedge device_unalign) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            second_q <= 1'b0;
        end else if (req_valid && req_ready) begin
            busy_q   <= 1'b1;
            second_q <= 1'b0;
        end else if (beat_valid && beat_ready) begin
            // Next request only after the last beat leaves.
            busy_q   <= !beat.last;
            second_q <= !beat.last;
        end
    end

endmodule

// File: axi_master/axi_lite_master.sv
`timescale 1ns/1ps

module axi_lite_master (
    input  logic                       device_unalign,
    input  logic                       rst_n,
    input  logic                       beat_valid,
    output logic                       beat_ready,
    input  lsu_pkg::bus_beat_t         beat,
    input  lsu_pkg::beat_ctx_t         ctx,
    output logic                       aw_valid,
    input  logic                       aw_ready,
    output lsu_pkg::axi_aw_t           aw,
    output logic                       w_valid,
    input  logic                       w_ready,
    output lsu_pkg::axi_w_t            w,
    input  logic                       b_valid,
    output logic                       b_ready,
    input  lsu_pkg::axi_b_t            b,
    output logic                       ar_valid,
    input  logic                       ar_ready,
    output lsu_pkg::axi_ar_t           ar,
    input  logic                       r_valid,
    output logic                       r_ready,
    input  lsu_pkg::axi_r_t            r,
    output logic                       done_valid,
    input  logic                       done_ready,
    output logic [lsu_pkg::xlen-1:0]   done_data,
    output logic                       done_err,
    output logic                       done_last,
    output lsu_pkg::beat_ctx_t         done_ctx
);

    typedef enum logic [2:0] {
        st_idle,
        st_wr_addr_data,
        st_wr_resp,
        st_rd_addr,
        st_rd_data
    } state_t;

    state_t             state;
    lsu_pkg::bus_beat_t beat_q;
    lsu_pkg::beat_ctx_t ctx_q;
    logic               aw_done;
    logic               w_done;
    logic               aw_fire;
    logic               w_fire;

    assign beat_ready = (state == st_idle);

    assign aw_valid = (state == st_wr_addr_data) && !aw_done;
    assign w_valid  = (state == st_wr_addr_data) && !w_done;
    assign ar_valid = (state == st_rd_addr);
    assign aw_fire  = aw_valid && aw_ready;
    assign w_fire   = w_valid && w_ready;

    assign aw.addr = beat_q.addr;
    assign aw.prot = 3'b000;
    assign w.data  = beat_q.data;
    assign w.strb  = beat_q.strb;
    assign ar.addr = beat_q.addr;
    assign ar.prot = 3'b000;

    // Response is taken only when the merger can take the completion.
    assign b_ready = (state == st_wr_resp) && done_ready;
    assign r_ready = (state == st_rd_data) && done_ready;

    assign done_valid = ((state == st_wr_resp) && b_valid) ||
                        ((state == st_rd_data) && r_valid);
    assign done_data  = (state == st_rd_data) ? r.data : '0;
    assign done_err   = (state == st_rd_data) ? (r.resp != lsu_pkg::resp_okay)
                                              : (b.resp != lsu_pkg::resp_okay);
    assign done_last  = beat_q.last;
    assign done_ctx   = ctx_q;

    always_ff @(posedge device_unalign) begin
        if (beat_valid && beat_ready) begin
            beat_q <= beat;
            ctx_q  <= ctx;
        end
    end

    always_ff @(posedge device_unalign) begin
        if (!rst_n) begin
            state   <= st_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (beat_valid) begin
                        state <= beat.store ? st_wr_addr_data : st_rd_addr;
                    end
                end
                st_wr_addr_data: begin
                    if (aw_fire) begin
                        aw_done <= 1'b1;
                    end
                    if (w_fire) begin
                        w_done <= 1'b1;
                    end
                    if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                        state <= st_wr_resp;
                    end
                end
                st_wr_resp: begin
                    if (b_valid && b_ready) begin
                        state <= st_idle;
                    end
                end
                st_rd_addr: begin
                    if (ar_ready) begin
                        state <= st_rd_data;
                    end
                end
                st_rd_data: begin
                    if (r_valid && r_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: source/load_merge.sv
`timescale 1ns/1ps

module load_merge (
    input  logic                     device_unalign,
    input  logic                     rst_n,
    input  logic                     done_valid,
    output logic                     done_ready,
    input  logic [lsu_pkg::xlen-1:0] done_data,
    input  logic                     done_err,
    input  logic                     done_last,
    input  lsu_pkg::beat_ctx_t       done_ctx,
    output logic                     rsp_valid,
    input  logic                     rsp_ready,
    output lsu_pkg::lsu_rsp_t        rsp
);

    logic [lsu_pkg::xlen-1:0]   hold_data;
    logic                       hold_err;
    logic [2*lsu_pkg::xlen-1:0] wide;
    logic [2*lsu_pkg::xlen-1:0] shifted;
    logic [lsu_pkg::xlen-1:0]   raw;
    logic [lsu_pkg::xlen-1:0]   value;
    logic                       sext;

    // First beats are always accepted, the last waits for the response buffer.
    assign done_ready = done_last ? rsp_ready : 1'b1;
    assign rsp_valid  = done_valid && done_last;

    assign wide = done_ctx.two_beat ? {done_data, hold_data}
                                    : {{lsu_pkg::xlen{1'b0}}, done_data};
    assign shifted = wide >> {done_ctx.offset, 3'b000};
    assign raw     = shifted[lsu_pkg::xlen-1:0];
    assign sext    = !done_ctx.is_unsigned;

    always_comb begin
        case (done_ctx.size)
            lsu_pkg::size_b: value = {{56{raw[7] & sext}}, raw[7:0]};
            lsu_pkg::size_h: value = {{48{raw[15] & sext}}, raw[15:0]};
            lsu_pkg::size_w: value = {{32{raw[31] & sext}}, raw[31:0]};
            default:         value = raw;
        endcase
    end

    assign rsp.data = done_ctx.store ? '0 : value;
    assign rsp.err  = done_err || (done_ctx.two_beat && hold_err);

    always_ff @(posedge device_unalign) begin
        if (done_valid && !done_last) begin
            hold_data <= done_data;
        end
    end

    always_ff @(posedge device_unalign) begin
        if (!rst_n) begin
            hold_err <= 1'b0;
        end else if (done_valid && done_ready) begin
            hold_err <= done_last ? 1'b0 : done_err;
        end
    end

endmodule

// File: source/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic               device_unalign,
    input  logic               rst_n,
    input  logic               req_valid,
    output logic               req_ready,
    input  lsu_pkg::lsu_req_t  req,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output lsu_pkg::lsu_rsp_t  rsp,
    output logic               aw_valid,
    input  logic               aw_ready,
    output lsu_pkg::axi_aw_t   aw,
    output logic               w_valid,
    input  logic               w_ready,
    output lsu_pkg::axi_w_t    w,
    input  logic               b_valid,
    output logic               b_ready,
    input  lsu_pkg::axi_b_t    b,
    output logic               ar_valid,
    input  logic               ar_ready,
    output lsu_pkg::axi_ar_t   ar,
    input  logic               r_valid,
    output logic               r_ready,
    input  lsu_pkg::axi_r_t    r
);

    logic                     sreq_valid;
    logic                     sreq_ready;
    lsu_pkg::lsu_req_t        sreq;
    logic                     beat_valid;
    logic                     beat_ready;
    lsu_pkg::bus_beat_t       beat;
    lsu_pkg::beat_ctx_t       ctx;
    logic                     done_valid;
    logic                     done_ready;
    logic [lsu_pkg::xlen-1:0] done_data;
    logic                     done_err;
    logic                     done_last;
    lsu_pkg::beat_ctx_t       done_ctx;
    logic                     mrsp_valid;
    logic                     mrsp_ready;
    lsu_pkg::lsu_rsp_t        mrsp;

    skid_buffer #(.T(lsu_pkg::lsu_req_t)) u_req_buf (
        .device_unalign (device_unalign),
        .rst_n          (rst_n),
        .in_valid       (req_valid),
        .in_ready       (req_ready),
        .in_data        (req),
        .out_valid      (sreq_valid),
        .out_ready      (sreq_ready),
        .out_data       (sreq)
    );

    access_split u_split (
        .device_unalign (device_unalign),
        .rst_n          (rst_n),
        .req_valid      (sreq_valid),
        .req_ready      (sreq_ready),
        .req            (sreq),
        .beat_valid     (beat_valid),
        .beat_ready     (beat_ready),
        .beat           (beat),
        .ctx            (ctx)
    );

    axi_lite_master u_master (
        .device_unalign (device_unalign),
        .rst_n          (rst_n),
        .beat_valid     (beat_valid),
        .beat_ready     (beat_ready),
        .beat           (beat),
        .ctx            (ctx),
        .aw_valid       (aw_valid),
        .aw_ready       (aw_ready),
        .aw             (aw),
        .w_valid        (w_valid),
        .w_ready        (w_ready),
        .w              (w),
        .b_valid        (b_valid),
        .b_ready        (b_ready),
        .b              (b),
        .ar_valid       (ar_valid),
        .ar_ready       (ar_ready),
        .ar             (ar),
        .r_valid        (r_valid),
        .r_ready        (r_ready),
        .r              (r),
        .done_valid     (done_valid),
        .done_ready     (done_ready),
        .done_data      (done_data),
        .done_err       (done_err),
        .done_last      (done_last),
        .done_ctx       (done_ctx)
    );

    load_merge u_merge (
        .device_unalign (device_unalign),
        .rst_n          (rst_n),
        .done_valid     (done_valid),
        .done_ready     (done_ready),
        .done_data      (done_data),
        .done_err       (done_err),
        .done_last      (done_last),
        .done_ctx       (done_ctx),
        .rsp_valid      (mrsp_valid),
        .rsp_ready      (mrsp_ready),
        .rsp            (mrsp)
    );

    skid_buffer #(.T(lsu_pkg::lsu_rsp_t)) u_rsp_buf (
        .device_unalign (device_unalign),
        .rst_n          (rst_n),
        .in_valid       (mrsp_valid),
        .in_ready       (mrsp_ready),
        .in_data        (mrsp),
        .out_valid      (rsp_valid),
        .out_ready      (rsp_ready),
        .out_data       (rsp)
    );

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic device_unalign,
    output logic rst_n
);

    initial begin
        device_unalign = 1'b0;
        forever #5 device_unalign = ~device_unalign;
    end

    // Reset spans four rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge device_unalign);
        @(negedge device_unalign);
        rst_n = 1'b1;
    end

endmodule

// File: tests/lsu_checker.sv
`timescale 1ns/1ps

module lsu_checker (
    input  logic              device_unalign,
    input  logic              rst_n,
    input  logic              req_valid,
    input  logic              req_ready,
    input  lsu_pkg::lsu_req_t req,
    input  logic              rsp_valid,
    input  logic              rsp_ready,
    input  lsu_pkg::lsu_rsp_t rsp,
    output int                outstanding,
    output int                check_count,
    output int                error_count
);

    logic [7:0]        shadow [4096];
    lsu_pkg::lsu_rsp_t exp_q [$];
    lsu_pkg::lsu_req_t req_q [$];
    lsu_pkg::lsu_rsp_t exp_rsp;
    lsu_pkg::lsu_req_t exp_req;

    // Extract and extend from the shadow bytes.
    function automatic lsu_pkg::lsu_rsp_t ref_result(input lsu_pkg::lsu_req_t r);
        lsu_pkg::lsu_rsp_t res;
        int                nbytes;
        int                i;
        nbytes   = 1 << r.size;
        res.data = '0;
        res.err  = 1'b0;
        for (i = 0; i < nbytes; i++) begin
            if (r.addr + i >= 32'h800) begin
                res.err = 1'b1;
            end
            res.data[8*i +: 8] = shadow[r.addr[11:0] + 12'(i)];
        end
        if (!r.is_unsigned && nbytes < 8 && res.data[8*nbytes-1]) begin
            for (i = 8 * nbytes; i < 64; i++) begin
                res.data[i] = 1'b1;
            end
        end
        if (r.store) begin
            res.data = '0;
        end
        return res;
    endfunction

    task automatic apply_store(input lsu_pkg::lsu_req_t r);
        int i;
        for (i = 0; i < (1 << r.size); i++) begin
            shadow[r.addr[11:0] + 12'(i)] = r.wdata[8*i +: 8];
        end
    endtask

    initial begin
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = 8'(i ^ (i >> 4) ^ 'h5a);
        end
        outstanding = 0;
        check_count = 0;
        error_count = 0;
    end

    always @(posedge device_unalign) begin
        if (rst_n && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                $display("Response arrived with no request outstanding at %0t", $time);
                error_count++;
            end else begin
                exp_rsp = exp_q.pop_front();
                exp_req = req_q.pop_front();
                check_count++;
                if (rsp.data !== exp_rsp.data) begin
                    $display("** Error: rsp.data expected %h actual %h (addr %h size %0d)",
                             exp_rsp.data, rsp.data, exp_req.addr, exp_req.size);
                    error_count++;
                end
                if (rsp.err !== exp_rsp.err) begin
                    $display("** Error: rsp.err expected %h actual %h (addr %h size %0d)",
                             exp_rsp.err, rsp.err, exp_req.addr, exp_req.size);
                    error_count++;
                end
            end
        end
        if (rst_n && req_valid && req_ready) begin
            exp_q.push_back(ref_result(req));
            req_q.push_back(req);
            if (req.store) begin
                apply_store(req);
            end
        end
        outstanding = exp_q.size();
    end

endmodule

// File: tests/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

    logic               device_unalign;
    logic               rst_n;
    logic               req_valid;
    logic               req_ready;
    lsu_pkg::lsu_req_t  req;
    logic               rsp_valid;
    logic               rsp_ready;
    lsu_pkg::lsu_rsp_t  rsp;
    logic               aw_valid;
    logic               aw_ready;
    lsu_pkg::axi_aw_t   aw;
    logic               w_valid;
    logic               w_ready;
    lsu_pkg::axi_w_t    w;
    logic               b_valid;
    logic               b_ready;
    lsu_pkg::axi_b_t    b;
    logic               ar_valid;
    logic               ar_ready;
    lsu_pkg::axi_ar_t   ar;
    logic               r_valid;
    logic               r_ready;
    lsu_pkg::axi_r_t    r;

    int outstanding;
    int check_count;
    int error_count;
    int bus_errors = 0;
    int issued = 0;
    int cycles = 0;
    int tests_run = 0;
    int tests_passed = 0;
    int err_mark = 0;
    int check_mark = 0;

    logic [31:0] stim_rng = 32'h3f1b;
    logic [31:0] bus_rng = 32'h3f1b;
    logic [31:0] bp_rng = 32'h3f1b;
    logic        stall_mode = 1'b0;
    int          stall_left = 0;

    // Memory model state.
    logic [7:0]      mem [4096];
    logic            aw_got;
    logic            w_got;
    logic [31:0]     wr_addr;
    lsu_pkg::axi_w_t wr_data;
    logic            b_pend;
    logic [1:0]      b_code;
    logic            r_pend;
    logic [63:0]     r_word;
    logic [1:0]      r_code;
    logic [11:0]     base_idx;
    int              lane;

    clock_gen u_clk (
        .device_unalign (device_unalign),
        .rst_n          (rst_n)
    );

    lsu_top lsu_top_inst (
        .device_unalign (device_unalign),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req            (req),
        .rsp_valid      (rsp_valid),
        .rsp_ready      (rsp_ready),
        .rsp            (rsp),
        .aw_valid       (aw_valid),
        .aw_ready       (aw_ready),
        .aw             (aw),
        .w_valid        (w_valid),
        .w_ready        (w_ready),
        .w              (w),
        .b_valid        (b_valid),
        .b_ready        (b_ready),
        .b              (b),
        .ar_valid       (ar_valid),
        .ar_ready       (ar_ready),
        .ar             (ar),
        .r_valid        (r_valid),
        .r_ready        (r_ready),
        .r              (r)
    );

    lsu_checker u_chk (
        .device_unalign (device_unalign),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req            (req),
        .rsp_valid      (rsp_valid),
        .rsp_ready      (rsp_ready),
        .rsp            (rsp),
        .outstanding    (outstanding),
        .check_count    (check_count),
        .error_count    (error_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    function automatic logic [63:0] random64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi, lo};
    endfunction

    function automatic logic [1:0] slave_resp(input logic [31:0] addr);
        return (addr >= 32'h800) ? 2'b10 : lsu_pkg::resp_okay;
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = 8'(i ^ (i >> 4) ^ 'h5a);
        end
        aw_got    = 1'b0;
        w_got     = 1'b0;
        b_pend    = 1'b0;
        r_pend    = 1'b0;
        b_code    = 2'b00;
        r_code    = 2'b00;
        r_word    = '0;
        aw_ready  = 1'b0;
        w_ready   = 1'b0;
        ar_ready  = 1'b0;
        b_valid   = 1'b0;
        b         = '0;
        r_valid   = 1'b0;
        r         = '0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
    end

    // AXI slave takes transfers on the rising edge.
    always @(posedge device_unalign) begin
        if (!rst_n) begin
            aw_got = 1'b0;
            w_got  = 1'b0;
            b_pend = 1'b0;
            r_pend = 1'b0;
        end else begin
            if (b_valid && b_ready) begin
                b_pend = 1'b0;
            end
            if (r_valid && r_ready) begin
                r_pend = 1'b0;
            end
            if (aw_valid && aw_ready) begin
                aw_got  = 1'b1;
                wr_addr = aw.addr;
                // Unprivileged, secure data access.
                if (aw.prot !== 3'b000) begin
                    $display("** Error: aw.prot expected %h actual %h", 3'b000, aw.prot);
                    bus_errors++;
                end
            end
            if (w_valid && w_ready) begin
                w_got   = 1'b1;
                wr_data = w;
            end
            if (aw_got && w_got) begin
                base_idx = {wr_addr[11:3], 3'b000};
                for (lane = 0; lane < 8; lane++) begin
                    if (wr_data.strb[lane]) begin
                        mem[base_idx + 12'(lane)] = wr_data.data[8*lane +: 8];
                    end
                end
                b_code = slave_resp(wr_addr);
                b_pend = 1'b1;
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
            if (ar_valid && ar_ready) begin
                if (ar.prot !== 3'b000) begin
                    $display("** Error: ar.prot expected %h actual %h", 3'b000, ar.prot);
                    bus_errors++;
                end
                base_idx = {ar.addr[11:3], 3'b000};
                for (lane = 0; lane < 8; lane++) begin
                    r_word[8*lane +: 8] = mem[base_idx + 12'(lane)];
                end
                r_code = slave_resp(ar.addr);
                r_pend = 1'b1;
            end
        end
    end

    always @(negedge device_unalign) begin
        bus_rng  = xorshift32(bus_rng);
        aw_ready = (bus_rng[1:0] != 2'b00) && !aw_got;
        w_ready  = (bus_rng[3:2] != 2'b00) && !w_got;
        ar_ready = (bus_rng[5:4] != 2'b00) && !r_pend;
        b_valid  = b_pend;
        b.resp   = b_code;
        r_valid  = r_pend;
        r.data   = r_word;
        r.resp   = r_code;
    end

    // Response back-pressure in random stretches.
    always @(negedge device_unalign) begin
        if (!stall_mode) begin
            rsp_ready = 1'b1;
        end else if (stall_left > 0) begin
            stall_left--;
        end else begin
            bp_rng     = xorshift32(bp_rng);
            rsp_ready  = bp_rng[0];
            stall_left = bp_rng[4:1];
        end
    end

    always @(posedge device_unalign) begin
        cycles++;
        if (cycles > 200 * issued + 1000) begin
            $display("Timeout after %0d cycles with %0d requests issued", cycles, issued);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic issue(input logic store, input logic [31:0] addr, input logic [1:0] size,
                         input logic uns, input logic [63:0] data);
        @(negedge device_unalign);
        req_valid       = 1'b1;
        req.store       = store;
        req.addr        = addr;
        req.size        = lsu_pkg::mem_size_t'(size);
        req.is_unsigned = uns;
        req.wdata       = data;
        do begin
            @(posedge device_unalign);
        end while (!req_ready);
        issued++;
    endtask

    task automatic wait_idle();
        @(negedge device_unalign);
        req_valid = 1'b0;
        while (outstanding != 0) begin
            @(negedge device_unalign);
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        int checks;
        wait_idle();
        errs   = error_count + bus_errors - err_mark;
        checks = check_count - check_mark;
        tests_run++;
        if (errs == 0) begin
            tests_passed++;
        end
        $display("%-22s %0d responses checked, %0d errors", name, checks, errs);
        err_mark   = error_count + bus_errors;
        check_mark = check_count;
    endtask

    task automatic random_access(input logic [31:0] base, input logic [31:0] span);
        logic [31:0] pick;
        logic [31:0] a;
        logic [63:0] d;
        pick = next_random();
        a    = base + next_random() % span;
        d    = random64();
        issue(pick[0], a, pick[2:1], pick[3], d);
    endtask

    task automatic aligned_round_trip();
        int          sz;
        int          off;
        logic [31:0] a;
        for (sz = 0; sz < 4; sz++) begin
            for (off = 0; off < 8; off += (1 << sz)) begin
                a = 32'h100 + 32'h10 * sz + off;
                issue(1'b1, a, sz[1:0], 1'b0, random64());
                issue(1'b0, a, sz[1:0], 1'b0, 64'h0);
            end
        end
        finish_test("aligned round trip");
    endtask

    task automatic sign_extension();
        int          sz;
        logic [31:0] a;
        logic [63:0] d;
        for (sz = 0; sz < 3; sz++) begin
            a = 32'h200 + 32'h8 * sz;
            // Top bit of the loaded field is set.
            d = random64() | (64'h1 << (8 * (1 << sz) - 1));
            issue(1'b1, a, sz[1:0], 1'b0, d);
            issue(1'b0, a, sz[1:0], 1'b0, 64'h0);
            issue(1'b0, a, sz[1:0], 1'b1, 64'h0);
        end
        finish_test("sign extension");
    endtask

    task automatic misaligned_round_trip();
        int          sz;
        int          off;
        logic [31:0] a;
        for (sz = 1; sz < 4; sz++) begin
            for (off = 9 - (1 << sz); off < 8; off++) begin
                a = 32'h300 + 32'h20 * sz + off;
                issue(1'b1, a, sz[1:0], 1'b0, random64());
                issue(1'b0, a, sz[1:0], 1'b0, 64'h0);
                // Both double words, to see the neighbors.
                issue(1'b0, a & ~32'h7, 2'd3, 1'b0, 64'h0);
                issue(1'b0, (a & ~32'h7) + 32'h8, 2'd3, 1'b0, 64'h0);
            end
        end
        finish_test("misaligned round trip");
    endtask

    task automatic backpressure_traffic();
        int n;
        stall_mode = 1'b1;
        for (n = 0; n < 40; n++) begin
            random_access(32'h400, 32'h100);
        end
        finish_test("response back-pressure");
        stall_mode = 1'b0;
    endtask

    task automatic error_status();
        issue(1'b1, 32'h7fc, 2'd3, 1'b0, random64());
        issue(1'b0, 32'h7fc, 2'd3, 1'b0, 64'h0);
        issue(1'b0, 32'h7fc, 2'd2, 1'b0, 64'h0);
        issue(1'b0, 32'h800, 2'd0, 1'b1, 64'h0);
        issue(1'b1, 32'h880, 2'd2, 1'b0, random64());
        issue(1'b0, 32'h8fe, 2'd1, 1'b0, 64'h0);
        issue(1'b0, 32'h7f8, 2'd3, 1'b0, 64'h0);
        finish_test("error status");
    endtask

    task automatic random_traffic();
        int n;
        for (n = 0; n < 300; n++) begin
            random_access(32'h0, 32'h900);
        end
        finish_test("random traffic");
    endtask

    initial begin
        wait (rst_n === 1'b1);
        aligned_round_trip();
        sign_extension();
        misaligned_round_trip();
        backpressure_traffic();
        error_status();
        random_traffic();
        $display("%0d of %0d tests passed, %0d responses checked, %0d errors",
                 tests_passed, tests_run, check_count, error_count + bus_errors);
        if (error_count == 0 && bus_errors == 0 && tests_passed == tests_run) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
common/lsu_pkg.sv
source/skid_buffer.sv
source/access_split.sv
axi_master/axi_lite_master.sv
source/load_merge.sv
source/lsu_top.sv
tests/clock_gen.sv
tests/lsu_checker.sv
tests/tb_lsu.sv
